// File: Bender.yml
package:
  name: dcore

sources:
  - design/dcore_pkg.sv
  - design/cfg_regs.sv
  - design/adc_unfold.sv
  - design/bit_slicer.sv
  - design/prbs_gen.sv
  - design/prbs_checker.sv
  - design/dcore_top.sv
  - target: test
    files:
      - verification/dcore_tb.sv

// File: build.f
design/dcore_pkg.sv
design/cfg_regs.sv
design/adc_unfold.sv
design/bit_slicer.sv
design/prbs_gen.sv
design/prbs_checker.sv
design/dcore_top.sv
verification/dcore_tb.sv

// File: design/adc_unfold.sv
`timescale 1ns/1ps

module adc_unfold (
    input  logic                 clk_adc,
    input  logic                 rst_n_i,
    input  dcore_pkg::adc_lane_t lanes_i [dcore_pkg::NTI],
    input  dcore_pkg::code_t     offset_i,
    output dcore_pkg::code_t     codes_o [dcore_pkg::NTI]
);

    // saturated code per lane, before the output register
    dcore_pkg::code_t sat_code [dcore_pkg::NTI];

    always_comb begin
        // one bit of headroom for the offset subtraction
        logic signed [dcore_pkg::NCODE:0] mag;
        logic signed [dcore_pkg::NCODE:0] diff;
        for (int i = 0; i < dcore_pkg::NTI; i++) begin
            mag = $signed({2'b00, lanes_i[i].magnitude});
            // sign high means a positive sample
            if (lanes_i[i].sign) begin
                diff = mag - offset_i;
            end else begin
                diff = -mag - offset_i;
            end
            // clip back into the code range
            if (diff > dcore_pkg::CODE_MAX) begin
                sat_code[i] = dcore_pkg::code_t'(dcore_pkg::CODE_MAX);
            end else if (diff < dcore_pkg::CODE_MIN) begin
                sat_code[i] = dcore_pkg::code_t'(dcore_pkg::CODE_MIN);
            end else begin
                sat_code[i] = diff[dcore_pkg::NCODE-1:0];
            end
        end
    end

    // one cycle from ADC sample to code
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < dcore_pkg::NTI; i++) begin
                codes_o[i] <= '0;
            end
        end else begin
            codes_o <= sat_code;
        end
    end

endmodule

// File: design/bit_slicer.sv
`timescale 1ns/1ps

module bit_slicer (
    input  logic                  clk_adc,
    input  logic                  rst_n_i,
    input  dcore_pkg::code_t      codes_i [dcore_pkg::NTI],
    input  dcore_pkg::code_t      threshold_i,
    input  logic                  src_bist_i,
    input  dcore_pkg::lane_word_t bist_bits_i,
    output dcore_pkg::lane_word_t bits_o
);

    // decision of each lane against the common threshold
    dcore_pkg::lane_word_t adc_bits;

    // source picked for the checker
    dcore_pkg::lane_word_t sel_bits;

    always_comb begin
        for (int i = 0; i < dcore_pkg::NTI; i++) begin
            // signed compare, equal to threshold slices to zero
            adc_bits[i] = (codes_i[i] > threshold_i);
        end
    end

    // BIST word bypasses the slicer completely
    assign sel_bits = src_bist_i ? bist_bits_i : adc_bits;

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bits_o <= '0;
        end else begin
            bits_o <= sel_bits;
        end
    end

endmodule

// File: design/cfg_regs.sv
`timescale 1ns/1ps

module cfg_regs (
    input  logic                  clk_adc,
    input  logic                  rst_n_i,
    input  logic                  cfg_req_i,
    input  dcore_pkg::cfg_req_t   cfg_i,
    output logic                  cfg_ack_o,
    output dcore_pkg::dcore_cfg_t cfg_o
);

    // new request seen while ack is still low
    logic take_word;

    assign take_word = cfg_req_i && !cfg_ack_o;

    // slave side of the four-phase handshake
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_ack_o <= 1'b0;
        end else if (take_word) begin
            cfg_ack_o <= 1'b1;
        end else if (!cfg_req_i) begin
            // master released req, close the transfer
            cfg_ack_o <= 1'b0;
        end
    end

    // register update, fields go live together with ack
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_o <= '0;
        end else if (take_word) begin
            case (cfg_i.addr)
                dcore_pkg::CFG_ADDR_SLICE: begin
                    cfg_o.threshold <= cfg_i.data.slice.threshold;
                    cfg_o.src_bist  <= cfg_i.data.slice.src_bist;
                end
                dcore_pkg::CFG_ADDR_LANE: begin
                    cfg_o.offset   <= cfg_i.data.lane.offset;
                    cfg_o.check_en <= cfg_i.data.lane.check_en;
                end
            endcase
        end
    end

    // ack only rises in answer to a request from the previous cycle
    property p_ack_needs_req;
        @(posedge clk_adc) disable iff (!rst_n_i)
            $rose(cfg_ack_o) |-> $past(cfg_req_i);
    endproperty

    a_ack_needs_req : assert property (p_ack_needs_req)
        else $error("cfg ack rose without a pending request");

    // master must hold the word until it has seen ack
    property p_word_stable;
        @(posedge clk_adc) disable iff (!rst_n_i)
            (cfg_req_i && !cfg_ack_o) |=> $stable(cfg_i);
    endproperty

    a_word_stable : assert property (p_word_stable)
        else $error("cfg word changed while request was pending");

endmodule

// File: design/dcore_pkg.sv
package dcore_pkg;

    // lane path dimensions
    localparam int NTI   = 16;
    localparam int NADC  = 8;
    localparam int NCODE = NADC + 1;

    // limits of a signed code, used when the offset is removed
    localparam int CODE_MAX = (2 ** (NCODE - 1)) - 1;
    localparam int CODE_MIN = -(2 ** (NCODE - 1));

    // PRBS7 with polynomial x^7 + x^6 + 1
    localparam int NPRBS    = 7;
    localparam int PRBS_TAP = 6;

    // error and bit counter width
    localparam int NCNT = 32;

    // configuration register map
    localparam logic CFG_ADDR_SLICE = 1'b0;
    localparam logic CFG_ADDR_LANE  = 1'b1;

    // one ADC lane as delivered by the analog core
    typedef struct packed {
        logic            sign;
        logic [NADC-1:0] magnitude;
    } adc_lane_t;

    // unfolded signed code
    typedef logic signed [NCODE-1:0] code_t;

    // one bit per lane, lane 0 is the earliest bit
    typedef logic [NTI-1:0] lane_word_t;

    // view of the config word at CFG_ADDR_SLICE
    typedef struct packed {
        logic       src_bist;
        code_t      threshold;
        logic [5:0] reserved;
    } slice_cfg_t;

    // view of the config word at CFG_ADDR_LANE
    typedef struct packed {
        code_t      offset;
        logic       check_en;
        logic [5:0] reserved;
    } lane_cfg_t;

    // the write address picks which view is valid
    typedef union packed {
        slice_cfg_t slice;
        lane_cfg_t  lane;
    } cfg_word_t;

    // word presented on the config port
    typedef struct packed {
        logic      addr;
        cfg_word_t data;
    } cfg_req_t;

    // live settings seen by the datapath
    typedef struct packed {
        code_t offset;
        code_t threshold;
        logic  src_bist;
        logic  check_en;
    } dcore_cfg_t;

endpackage

// File: design/dcore_top.sv
`timescale 1ns/1ps

module dcore_top (
    input  logic                       clk_adc,
    input  logic                       rst_n_i,
    input  dcore_pkg::adc_lane_t       adc_i [dcore_pkg::NTI],
    input  logic                       cfg_req_i,
    input  dcore_pkg::cfg_req_t        cfg_i,
    output logic                       cfg_ack_o,
    output dcore_pkg::lane_word_t      rx_bits_o,
    output logic [dcore_pkg::NCNT-1:0] err_count_o,
    output logic [dcore_pkg::NCNT-1:0] bit_count_o
);

    dcore_pkg::dcore_cfg_t cfg;
    dcore_pkg::code_t      codes [dcore_pkg::NTI];
    dcore_pkg::lane_word_t bist_bits;

    cfg_regs cfg_regs_i (
        .clk_adc   (clk_adc),
        .rst_n_i   (rst_n_i),
        .cfg_req_i (cfg_req_i),
        .cfg_i     (cfg_i),
        .cfg_ack_o (cfg_ack_o),
        .cfg_o     (cfg)
    );

    // sign/magnitude to signed code, fixed offset removed
    adc_unfold adc_unfold_i (
        .clk_adc  (clk_adc),
        .rst_n_i  (rst_n_i),
        .lanes_i  (adc_i),
        .offset_i (cfg.offset),
        .codes_o  (codes)
    );

    prbs_gen prbs_gen_i (
        .clk_adc (clk_adc),
        .rst_n_i (rst_n_i),
        .bits_o  (bist_bits)
    );

    bit_slicer bit_slicer_i (
        .clk_adc     (clk_adc),
        .rst_n_i     (rst_n_i),
        .codes_i     (codes),
        .threshold_i (cfg.threshold),
        .src_bist_i  (cfg.src_bist),
        .bist_bits_i (bist_bits),
        .bits_o      (rx_bits_o)
    );

    prbs_checker prbs_checker_i (
        .clk_adc     (clk_adc),
        .rst_n_i     (rst_n_i),
        .check_en_i  (cfg.check_en),
        .bits_i      (rx_bits_o),
        .err_count_o (err_count_o),
        .bit_count_o (bit_count_o)
    );

endmodule

// File: design/prbs_checker.sv
`timescale 1ns/1ps

module prbs_checker (
    input  logic                        clk_adc,
    input  logic                        rst_n_i,
    input  logic                        check_en_i,
    input  dcore_pkg::lane_word_t       bits_i,
    output logic [dcore_pkg::NCNT-1:0]  err_count_o,
    output logic [dcore_pkg::NCNT-1:0]  bit_count_o
);

    // last NPRBS bits of the previous word, index 0 is the oldest
    logic [dcore_pkg::NPRBS-1:0] hist_q;

    // set once the history holds real data
    logic primed_q;

    // history followed by the current word, in time order
    logic [dcore_pkg::NTI+dcore_pkg::NPRBS-1:0] stream;

    // mismatch per lane and their sum
    dcore_pkg::lane_word_t       err_flags;
    logic [dcore_pkg::NCNT-1:0]  err_sum;

    assign stream = {bits_i, hist_q};

    // each bit must equal the XOR of the bits 7 and 6 positions back
    always_comb begin
        for (int i = 0; i < dcore_pkg::NTI; i++) begin
            err_flags[i] = bits_i[i] ^ stream[i]
                         ^ stream[i + dcore_pkg::NPRBS - dcore_pkg::PRBS_TAP];
        end
    end

    // population count of the mismatches
    always_comb begin
        err_sum = '0;
        for (int i = 0; i < dcore_pkg::NTI; i++) begin
            err_sum = err_sum + err_flags[i];
        end
    end

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hist_q      <= '0;
            primed_q    <= 1'b0;
            err_count_o <= '0;
            bit_count_o <= '0;
        end else if (!check_en_i) begin
            // disabled, hold everything cleared
            hist_q      <= '0;
            primed_q    <= 1'b0;
            err_count_o <= '0;
            bit_count_o <= '0;
        end else begin
            hist_q   <= bits_i[dcore_pkg::NTI-1 -: dcore_pkg::NPRBS];
            primed_q <= 1'b1;
            // first word after enable only fills the history
            if (primed_q) begin
                err_count_o <= err_count_o + err_sum;
                bit_count_o <= bit_count_o + dcore_pkg::NCNT'(dcore_pkg::NTI);
            end
        end
    end

    a_err_le_bits : assert property (
        @(posedge clk_adc) disable iff (!rst_n_i) err_count_o <= bit_count_o
    ) else $error("PRBS error count exceeds checked bit count");

endmodule

// File: design/prbs_gen.sv
`timescale 1ns/1ps

module prbs_gen (
    input  logic                  clk_adc,
    input  logic                  rst_n_i,
    output dcore_pkg::lane_word_t bits_o
);

    // LFSR state, bit 0 holds the most recent output bit
    logic [dcore_pkg::NPRBS-1:0] state_q;
    logic [dcore_pkg::NPRBS-1:0] state_d;

    // unroll NTI LFSR steps, lane 0 first
    always_comb begin
        logic [dcore_pkg::NPRBS-1:0] s;
        s = state_q;
        for (int i = 0; i < dcore_pkg::NTI; i++) begin
            bits_o[i] = s[dcore_pkg::NPRBS-1] ^ s[dcore_pkg::PRBS_TAP-1];
            s         = {s[dcore_pkg::NPRBS-2:0], bits_o[i]};
        end
        state_d = s;
    end

    // seeded with all ones
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= '1;
        end else begin
            state_q <= state_d;
        end
    end

    // all-zero state would lock up the sequence
    a_state_live : assert property (
        @(posedge clk_adc) disable iff (!rst_n_i) state_q != '0
    ) else $error("PRBS generator state collapsed to zero");

endmodule

// File: verification/dcore_tb.sv
`timescale 1ns/1ps

module dcore_tb;

    localparam int WAIT_LIMIT = 64;
    // lane that gets the single corrupted bit
    localparam int FLIP_LANE  = 12;

    logic                         clk_adc;
    logic                         rst_n_i;
    dcore_pkg::adc_lane_t         adc_i [dcore_pkg::NTI];
    logic                         cfg_req_i;
    dcore_pkg::cfg_req_t          cfg_i;
    logic                         cfg_ack_o;
    dcore_pkg::lane_word_t        rx_bits_o;
    logic [dcore_pkg::NCNT-1:0]   err_count_o;
    logic [dcore_pkg::NCNT-1:0]   bit_count_o;

    int              err_cnt;
    int              timeout_cnt;
    logic [15:0]     lfsr_q;
    // reference PRBS7 history, bit 0 newest
    logic [6:0]      prbs_hist;
    logic            drive_random;
    logic            drive_prbs;
    logic            flip_next;
    logic            slice_active;
    logic            bist_check;
    int              tb_offset;
    int              tb_threshold;

    // expected slicer output and its two-cycle delay line
    dcore_pkg::lane_word_t exp_now;
    dcore_pkg::lane_word_t exp_d1;
    dcore_pkg::lane_word_t exp_d2;
    logic                  vld_d1;
    logic                  vld_d2;

    dcore_top DUT (
        .clk_adc     (clk_adc),
        .rst_n_i     (rst_n_i),
        .adc_i       (adc_i),
        .cfg_req_i   (cfg_req_i),
        .cfg_i       (cfg_i),
        .cfg_ack_o   (cfg_ack_o),
        .rx_bits_o   (rx_bits_o),
        .err_count_o (err_count_o),
        .bit_count_o (bit_count_o)
    );

    initial clk_adc = 1'b0;
    always #2 clk_adc = ~clk_adc;

    task automatic flag_error(input string msg);
        err_cnt++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic note_timeout(input string what);
        timeout_cnt++;
        $display("Timeout at %0t ns: gave up waiting for %s", $time, what);
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    // sixteen stream bits, lane 0 first
    task automatic next_prbs_word(output dcore_pkg::lane_word_t w);
        logic b;
        for (int i = 0; i < dcore_pkg::NTI; i++) begin
            // taps at 7 and 6 bits back
            b         = prbs_hist[6] ^ prbs_hist[5];
            w[i]      = b;
            prbs_hist = {prbs_hist[5:0], b};
        end
    endtask

    // unfold, remove offset, clip, compare
    function automatic logic slice_bit(input dcore_pkg::adc_lane_t lane, input int offset,
                                       input int threshold);
        int val;
        val = lane.magnitude;
        if (!lane.sign) begin
            val = -val;
        end
        val = val - offset;
        if (val > dcore_pkg::CODE_MAX) begin
            val = dcore_pkg::CODE_MAX;
        end
        if (val < dcore_pkg::CODE_MIN) begin
            val = dcore_pkg::CODE_MIN;
        end
        return val > threshold;
    endfunction

    task automatic cfg_write(input logic addr, input dcore_pkg::cfg_word_t data);
        int n;
        n = 0;
        while (cfg_ack_o && n < WAIT_LIMIT) begin
            @(negedge clk_adc);
            n++;
        end
        if (cfg_ack_o) note_timeout("cfg ack to drop before a new write");
        cfg_i.addr = addr;
        cfg_i.data = data;
        cfg_req_i  = 1'b1;
        n = 0;
        do begin
            @(negedge clk_adc);
            n++;
        end while (!cfg_ack_o && n < WAIT_LIMIT);
        if (!cfg_ack_o) note_timeout("cfg ack to rise");
        cfg_req_i = 1'b0;
        n = 0;
        do begin
            @(negedge clk_adc);
            n++;
        end while (cfg_ack_o && n < WAIT_LIMIT);
        if (cfg_ack_o) note_timeout("cfg ack to fall after req dropped");
    endtask

    task automatic wait_for_count();
        int n;
        n = 0;
        while (bit_count_o == '0 && n < WAIT_LIMIT) begin
            @(negedge clk_adc);
            n++;
        end
        if (bit_count_o == '0) note_timeout("the checker to start counting");
    endtask

    always @(negedge clk_adc) begin : drive_lanes
        logic [31:0]           v;
        dcore_pkg::lane_word_t w;
        if (drive_random) begin
            for (int i = 0; i < dcore_pkg::NTI; i++) begin
                take_bits(dcore_pkg::NADC + 1, v);
                adc_i[i].sign      = v[dcore_pkg::NADC];
                adc_i[i].magnitude = v[dcore_pkg::NADC-1:0];
            end
        end else if (drive_prbs) begin
            next_prbs_word(w);
            if (flip_next) begin
                w[FLIP_LANE] = ~w[FLIP_LANE];
                flip_next    = 1'b0;
            end
            // stream rides on the signs, magnitude kept nonzero
            for (int i = 0; i < dcore_pkg::NTI; i++) begin
                take_bits(dcore_pkg::NADC, v);
                adc_i[i].sign      = w[i];
                adc_i[i].magnitude = v[dcore_pkg::NADC-1:0] | 8'h01;
            end
        end else begin
            for (int i = 0; i < dcore_pkg::NTI; i++) begin
                adc_i[i] = '0;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < dcore_pkg::NTI; i++) begin
            exp_now[i] = slice_bit(adc_i[i], tb_offset, tb_threshold);
        end
    end

    always @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exp_d1 <= '0;
            exp_d2 <= '0;
            vld_d1 <= 1'b0;
            vld_d2 <= 1'b0;
        end else begin
            exp_d1 <= exp_now;
            exp_d2 <= exp_d1;
            vld_d1 <= slice_active;
            vld_d2 <= vld_d1;
        end
    end

    a_reset_state : assert property (@(posedge clk_adc)
        $rose(rst_n_i) |-> (!cfg_ack_o && rx_bits_o == '0 && err_count_o == '0
                            && bit_count_o == '0))
        else flag_error("outputs not cleared after reset");

    a_ack_rise : assert property (@(posedge clk_adc) disable iff (!rst_n_i)
        $rose(cfg_ack_o) |-> $past(cfg_req_i))
        else flag_error("cfg ack rose without req");

    a_ack_fall : assert property (@(posedge clk_adc) disable iff (!rst_n_i)
        $fell(cfg_ack_o) |-> !$past(cfg_req_i))
        else flag_error("cfg ack fell while req was still high");

    a_slice : assert property (@(posedge clk_adc) disable iff (!rst_n_i)
        vld_d2 |-> rx_bits_o == exp_d2)
        else flag_error("rx_bits_o differs from the sliced ADC lanes");

    a_bist_clean : assert property (@(posedge clk_adc) disable iff (!rst_n_i)
        bist_check |-> err_count_o == '0)
        else flag_error("errors counted on the BIST loopback");

    a_bist_count : assert property (@(posedge clk_adc) disable iff (!rst_n_i)
        (bist_check && $past(bist_check) && $past(bit_count_o) != '0)
            |-> bit_count_o == $past(bit_count_o) + dcore_pkg::NTI)
        else flag_error("bit count did not advance by one word");

    a_disable_clears : assert property (@(posedge clk_adc) disable iff (!rst_n_i)
        ($rose(cfg_ack_o) && cfg_i.addr == dcore_pkg::CFG_ADDR_LANE
         && !cfg_i.data.lane.check_en) |=> (err_count_o == '0 && bit_count_o == '0))
        else flag_error("counters not cleared after checking was disabled");

    initial begin : stimulus
        logic [31:0]           v;
        dcore_pkg::code_t      off;
        dcore_pkg::code_t      thr;
        dcore_pkg::cfg_word_t  w;
        err_cnt      = 0;
        timeout_cnt  = 0;
        lfsr_q       = 16'd26;
        prbs_hist    = 7'b1010011;
        rst_n_i      = 1'b0;
        cfg_req_i    = 1'b0;
        cfg_i        = '0;
        drive_random = 1'b0;
        drive_prbs   = 1'b0;
        flip_next    = 1'b0;
        slice_active = 1'b0;
        bist_check   = 1'b0;
        tb_offset    = 0;
        tb_threshold = 0;
        for (int i = 0; i < dcore_pkg::NTI; i++) begin
            adc_i[i] = '0;
        end
        repeat (2) @(negedge clk_adc);
        rst_n_i = 1'b1;
        repeat (2) @(negedge clk_adc);

        // ADC slicing over a few random offset and threshold pairs
        for (int round = 0; round < 4; round++) begin
            take_bits(dcore_pkg::NCODE, v);
            off = v[dcore_pkg::NCODE-1:0];
            take_bits(dcore_pkg::NCODE, v);
            thr = v[dcore_pkg::NCODE-1:0];
            tb_offset    = off;
            tb_threshold = thr;
            w = '0;
            w.lane.offset = off;
            cfg_write(dcore_pkg::CFG_ADDR_LANE, w);
            w = '0;
            w.slice.threshold = thr;
            cfg_write(dcore_pkg::CFG_ADDR_SLICE, w);
            drive_random = 1'b1;
            slice_active = 1'b1;
            repeat (60) @(negedge clk_adc);
            drive_random = 1'b0;
            slice_active = 1'b0;
        end

        // BIST loopback into the checker
        w = '0;
        w.slice.src_bist = 1'b1;
        cfg_write(dcore_pkg::CFG_ADDR_SLICE, w);
        w = '0;
        w.lane.check_en = 1'b1;
        cfg_write(dcore_pkg::CFG_ADDR_LANE, w);
        wait_for_count();
        bist_check = 1'b1;
        repeat (40) @(negedge clk_adc);
        bist_check = 1'b0;
        w = '0;
        cfg_write(dcore_pkg::CFG_ADDR_LANE, w);

        // PRBS7 through the ADC signs with one corrupted bit
        drive_prbs = 1'b1;
        w = '0;
        cfg_write(dcore_pkg::CFG_ADDR_SLICE, w);
        repeat (4) @(negedge clk_adc);
        w = '0;
        w.lane.check_en = 1'b1;
        cfg_write(dcore_pkg::CFG_ADDR_LANE, w);
        wait_for_count();
        repeat (3) @(negedge clk_adc);
        flip_next = 1'b1;
        repeat (8) @(negedge clk_adc);
        assert (err_count_o == 3)
            else flag_error($sformatf("expected 3 errors, counted %0d", err_count_o));
        assert (bit_count_o != '0 && bit_count_o % dcore_pkg::NTI == 0)
            else flag_error($sformatf("bit count %0d is not whole words", bit_count_o));
        w = '0;
        cfg_write(dcore_pkg::CFG_ADDR_LANE, w);
        drive_prbs = 1'b0;
        repeat (4) @(negedge clk_adc);

        $display("checks failed: %0d, timeouts: %0d", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
